// ==== board_pkg.sv ====
`default_nettype none

package board_pkg;

    // Bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // Address map, byte addresses
    localparam logic [ADDR_W-1:0] RAM_BASE       = 16'h0000;
    localparam logic [ADDR_W-1:0] KEY_DATA_ADDR  = 16'h1000;
    localparam logic [ADDR_W-1:0] KEY_STAT_ADDR  = 16'h1004;
    localparam logic [ADDR_W-1:0] UART_DATA_ADDR = 16'h1100;
    localparam logic [ADDR_W-1:0] UART_STAT_ADDR = 16'h1104;

    // Keyboard status register bits
    localparam int KEY_VALID_BIT   = 0;
    localparam int KEY_OVERRUN_BIT = 1;
    localparam int KEY_PARITY_BIT  = 2;

    // UART status register bits
    localparam int UART_BUSY_BIT = 0;

    // Address decode result
    typedef enum logic [1:0] {
        SLV_NONE,
        SLV_RAM,
        SLV_KEY,
        SLV_UART
    } slave_e;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_ACCESS,
        BUS_RESPOND
    } bus_state_e;

    // PS/2 receive frame position
    typedef enum logic [1:0] {
        PS2_IDLE,
        PS2_DATA,
        PS2_PARITY,
        PS2_STOP
    } ps2_state_e;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage

`default_nettype wire

// ==== board_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_properties (
    input logic CLOCK_50,
    input logic KEY0,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic irq,
    input logic uart_txd,
    input logic uart_busy
);

    logic        pending;
    logic        req_start;
    int unsigned fail_count = 0;

    // Request taken by an idle controller or right on the acknowledge cycle
    assign req_start = wb_cyc && wb_stb && (!pending || wb_ack);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pending <= 1'b0;
        end else if (req_start) begin
            pending <= 1'b1;
        end else if (wb_ack) begin
            pending <= 1'b0;
        end
    end

    ack_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack lasted more than one cycle");
            fail_count++;
        end

    // Acknowledge two edges after the sampling edge
    ack_latency: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        req_start |=> !wb_ack ##1 !wb_ack ##1 wb_ack)
        else begin
            $error("wb_ack not two cycles after the request");
            fail_count++;
        end

    // Interrupt starts low once reset is released
    irq_after_reset: assert property (@(posedge CLOCK_50)
        $rose(KEY0) |-> !irq)
        else begin
            $error("irq high after reset");
            fail_count++;
        end

    txd_idle_high: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !uart_busy |-> uart_txd)
        else begin
            $error("uart_txd low while the transmitter is idle");
            fail_count++;
        end

endmodule

bind board_top board_properties u_props (
    .CLOCK_50  (CLOCK_50),
    .KEY0      (KEY0),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .irq       (irq),
    .uart_txd  (uart_txd),
    .uart_busy (u_uart.busy)
);

`default_nettype wire

// ==== board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_top #(
    parameter int RAM_WORDS = 1024,
    parameter int BAUD_DIV  = 434
) (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [board_pkg::ADDR_W-1:0] wb_adr,
    input  logic [board_pkg::DATA_W-1:0] wb_dat_w,
    output logic [board_pkg::DATA_W-1:0] wb_dat_r,
    output logic                         wb_ack,
    input  logic                         ps2_clk,
    input  logic                         ps2_dat,
    input  logic                         irq_ack,
    output logic                         irq,
    output logic                         uart_txd
);

    // One access channel per peripheral
    periph_if ram_if ();
    periph_if key_if ();
    periph_if uart_if ();

    bus_controller #(
        .RAM_WORDS (RAM_WORDS)
    ) u_bus (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .cyc      (wb_cyc),
        .stb      (wb_stb),
        .we       (wb_we),
        .adr      (wb_adr),
        .dat_w    (wb_dat_w),
        .dat_r    (wb_dat_r),
        .ack      (wb_ack),
        .ram      (ram_if.controller),
        .key      (key_if.controller),
        .uart     (uart_if.controller)
    );

    main_memory #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .CLOCK_50 (CLOCK_50),
        .bus      (ram_if.peripheral)
    );

    keyboard_port u_key (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus      (key_if.peripheral),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .irq      (irq),
        .irq_ack  (irq_ack)
    );

    uart_tx #(
        .BAUD_DIV (BAUD_DIV)
    ) u_uart (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus      (uart_if.peripheral),
        .txd      (uart_txd)
    );

endmodule

`default_nettype wire

// ==== bus_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_controller #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  logic                         cyc,
    input  logic                         stb,
    input  logic                         we,
    input  logic [board_pkg::ADDR_W-1:0] adr,
    input  logic [board_pkg::DATA_W-1:0] dat_w,
    output logic [board_pkg::DATA_W-1:0] dat_r,
    output logic                         ack,
    periph_if.controller                 ram,
    periph_if.controller                 key,
    periph_if.controller                 uart
);
    import board_pkg::*;

    localparam int RAM_BYTES = RAM_WORDS * 4;

    bus_state_e        state;
    slave_e            slave_q;
    slave_e            slave_d;
    logic              we_q;
    logic [ADDR_W-3:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] rdata_mux;

    // Address decode of the incoming request
    always_comb begin
        slave_d = SLV_NONE;
        if (int'(adr) >= int'(RAM_BASE) && int'(adr) < int'(RAM_BASE) + RAM_BYTES) begin
            slave_d = SLV_RAM;
        end else if (adr == KEY_DATA_ADDR || adr == KEY_STAT_ADDR) begin
            slave_d = SLV_KEY;
        end else if (adr == UART_DATA_ADDR || adr == UART_STAT_ADDR) begin
            slave_d = SLV_UART;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state   <= BUS_IDLE;
            slave_q <= SLV_NONE;
            ack     <= 1'b0;
        end else begin
            ack <= 1'b0;
            case (state)
                BUS_IDLE: begin
                    if (cyc && stb) begin
                        state   <= BUS_ACCESS;
                        slave_q <= slave_d;
                    end
                end
                // Peripheral registers its read data here
                BUS_ACCESS: state <= BUS_RESPOND;
                BUS_RESPOND: begin
                    state <= BUS_IDLE;
                    ack   <= 1'b1;
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    // Request captured once, held through the access
    always_ff @(posedge CLOCK_50) begin
        if (state == BUS_IDLE && cyc && stb) begin
            we_q    <= we;
            addr_q  <= adr[ADDR_W-1:2];
            wdata_q <= dat_w;
        end
        if (state == BUS_RESPOND) begin
            dat_r <= rdata_mux;
        end
    end

    // Unmapped reads return zero
    always_comb begin
        case (slave_q)
            SLV_RAM:  rdata_mux = ram.rdata;
            SLV_KEY:  rdata_mux = key.rdata;
            SLV_UART: rdata_mux = uart.rdata;
            default:  rdata_mux = '0;
        endcase
    end

    assign ram.sel    = (state == BUS_ACCESS) && (slave_q == SLV_RAM);
    assign key.sel    = (state == BUS_ACCESS) && (slave_q == SLV_KEY);
    assign uart.sel   = (state == BUS_ACCESS) && (slave_q == SLV_UART);

    assign ram.we     = we_q;
    assign ram.addr   = addr_q;
    assign ram.wdata  = wdata_q;
    assign key.we     = we_q;
    assign key.addr   = addr_q;
    assign key.wdata  = wdata_q;
    assign uart.we    = we_q;
    assign uart.addr  = addr_q;
    assign uart.wdata = wdata_q;

endmodule

`default_nettype wire

// ==== keyboard_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module keyboard_port (
    input  logic         CLOCK_50,
    input  logic         KEY0,
    periph_if.peripheral bus,
    input  logic         ps2_clk,
    input  logic         ps2_dat,
    output logic         irq,
    input  logic         irq_ack
);
    import board_pkg::*;

    localparam logic [ADDR_W-3:0] DATA_WORD = KEY_DATA_ADDR[ADDR_W-1:2];

    logic        clk_meta;
    logic        clk_sync;
    logic        clk_prev;
    logic        dat_meta;
    logic        dat_sync;
    logic        ps2_fall;
    ps2_state_e  state;
    logic [2:0]  bit_cnt;
    logic [7:0]  shift_reg;
    logic        parity_bit;
    logic        frame_end;
    logic        frame_ok;
    logic [7:0]  scan_code;
    logic        valid;
    logic        overrun;
    logic        parity_err;
    logic        rd_data;
    logic [DATA_W-1:0] status;

    // Two-flop synchronizers, line idles high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_meta <= 1'b1;
            clk_sync <= 1'b1;
            clk_prev <= 1'b1;
            dat_meta <= 1'b1;
            dat_sync <= 1'b1;
        end else begin
            clk_meta <= ps2_clk;
            clk_sync <= clk_meta;
            clk_prev <= clk_sync;
            dat_meta <= ps2_dat;
            dat_sync <= dat_meta;
        end
    end

    assign ps2_fall  = clk_prev && !clk_sync;
    assign frame_end = ps2_fall && (state == PS2_STOP);
    // Odd parity over data and parity bit, stop must be high
    assign frame_ok  = dat_sync && (^{shift_reg, parity_bit});
    assign rd_data   = bus.sel && !bus.we && (bus.addr == DATA_WORD);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= PS2_IDLE;
            bit_cnt    <= 3'd0;
            valid      <= 1'b0;
            overrun    <= 1'b0;
            parity_err <= 1'b0;
            irq        <= 1'b0;
        end else begin
            if (ps2_fall) begin
                case (state)
                    PS2_IDLE: begin
                        // Start bit is low
                        if (!dat_sync) begin
                            state   <= PS2_DATA;
                            bit_cnt <= 3'd0;
                        end
                    end
                    PS2_DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= PS2_PARITY;
                        end
                    end
                    PS2_PARITY: state <= PS2_STOP;
                    PS2_STOP:   state <= PS2_IDLE;
                    default:    state <= PS2_IDLE;
                endcase
            end
            if (rd_data) begin
                valid      <= 1'b0;
                overrun    <= 1'b0;
                parity_err <= 1'b0;
            end
            if (irq_ack) begin
                irq <= 1'b0;
            end
            // A new frame wins over read-clear and acknowledge
            if (frame_end) begin
                if (frame_ok) begin
                    valid <= 1'b1;
                    irq   <= 1'b1;
                    if (valid && !rd_data) begin
                        overrun <= 1'b1;
                    end
                end else begin
                    parity_err <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        status                  = '0;
        status[KEY_VALID_BIT]   = valid;
        status[KEY_OVERRUN_BIT] = overrun;
        status[KEY_PARITY_BIT]  = parity_err;
    end

    // Frame shifter, code register and read data
    always_ff @(posedge CLOCK_50) begin
        if (ps2_fall && state == PS2_DATA) begin
            shift_reg <= {dat_sync, shift_reg[7:1]};
        end
        if (ps2_fall && state == PS2_PARITY) begin
            parity_bit <= dat_sync;
        end
        if (frame_end && frame_ok) begin
            scan_code <= shift_reg;
        end
        if (bus.sel) begin
            bus.rdata <= (bus.addr == DATA_WORD) ? {{(DATA_W-8){1'b0}}, scan_code} : status;
        end
    end

endmodule

`default_nettype wire

// ==== main_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_memory #(
    parameter int RAM_WORDS = 1024
) (
    input  logic         CLOCK_50,
    periph_if.peripheral bus
);
    import board_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    // Word array, inferred as block RAM
    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0]  idx;

    // Low word-address bits select the entry
    assign idx = bus.addr[IDX_W-1:0];

    always_ff @(posedge CLOCK_50) begin
        if (bus.sel) begin
            if (bus.we) begin
                mem[idx] <= bus.wdata;
            end
            // Read-first port, old word comes out on a write
            bus.rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

// ==== periph_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface periph_if;
    import board_pkg::*;

    // One-cycle access strobe from the bus controller
    logic              sel;
    logic              we;
    // Word address, byte offset already stripped
    logic [ADDR_W-3:0] addr;
    logic [DATA_W-1:0] wdata;
    // Registered by the peripheral, valid the cycle after sel
    logic [DATA_W-1:0] rdata;

    modport controller (
        output sel,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport peripheral (
        input  sel,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== tb.f ====
board_pkg.sv
periph_if.sv
bus_controller.sv
main_memory.sv
keyboard_port.sv
uart_tx.sv
board_top.sv
board_properties.sv
tb_board.sv

// ==== tb_board.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_board;
    import board_pkg::*;

    localparam int RAM_WORDS    = 1024;
    localparam int BAUD_DIV     = 8;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int ACK_CYCLES   = 2;
    localparam int ACK_LIMIT    = 16;
    localparam int PS2_HALF     = 16;
    localparam int RAM_TESTS    = 4;
    localparam int PS2_FRAME    = 22 * PS2_HALF;
    localparam int UART_FRAME   = 10 * BAUD_DIV;
    localparam int LONGEST_STEP = (PS2_FRAME > UART_FRAME) ? PS2_FRAME : UART_FRAME;

    // Status register values built from the bit positions
    localparam logic [DATA_W-1:0] ST_VALID   = 32'd1 << KEY_VALID_BIT;
    localparam logic [DATA_W-1:0] ST_OVERRUN = 32'd1 << KEY_OVERRUN_BIT;
    localparam logic [DATA_W-1:0] ST_PARITY  = 32'd1 << KEY_PARITY_BIT;
    localparam logic [DATA_W-1:0] ST_BUSY    = 32'd1 << UART_BUSY_BIT;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_PS2,
        OP_PS2_BAD,
        OP_IRQ_ACK,
        OP_IRQ,
        OP_UART
    } op_e;

    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] expected;
    } step_t;

    logic              CLOCK_50;
    logic              KEY0;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat_w;
    logic [DATA_W-1:0] wb_dat_r;
    logic              wb_ack;
    logic              ps2_clk;
    logic              ps2_dat;
    logic              irq_ack;
    logic              irq;
    logic              uart_txd;

    step_t       steps[$];
    logic [7:0]  rx_bytes[$];
    int          errors = 0;
    int          checks = 0;
    logic        table_ready;
    int unsigned seed_val;

    board_top #(
        .RAM_WORDS (RAM_WORDS),
        .BAUD_DIV  (BAUD_DIV)
    ) DUT (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .irq_ack  (irq_ack),
        .irq      (irq),
        .uart_txd (uart_txd)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0d ns: %s, got %h expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic void add_step(op_e op, logic [ADDR_W-1:0] addr,
                                     logic [DATA_W-1:0] data, logic [DATA_W-1:0] expected);
        step_t s;
        s.op       = op;
        s.addr     = addr;
        s.data     = data;
        s.expected = expected;
        steps.push_back(s);
    endfunction

    // One classic cycle with inputs held until the acknowledge
    task automatic wb_access(input logic we, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
        int cycles;
        @(negedge CLOCK_50);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = wdata;
        cycles   = 0;
        while (!wb_ack && cycles < ACK_LIMIT) begin
            @(negedge CLOCK_50);
            cycles++;
        end
        if (!wb_ack) begin
            errors++;
            $display("No acknowledge for address %h within %0d cycles", addr, ACK_LIMIT);
        end else begin
            // First negedge falls after the sampling edge
            check_value(cycles - 1, ACK_CYCLES, $sformatf("ack latency at %h", addr));
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        wb_access(1'b0, addr, '0, data);
    endtask

    task automatic ps2_send(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        // Start, data LSB first, odd parity, stop
        frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        @(negedge CLOCK_50);
        for (int i = 0; i < 11; i++) begin
            ps2_dat = frame[i];
            repeat (PS2_HALF) @(negedge CLOCK_50);
            ps2_clk = 1'b0;
            repeat (PS2_HALF) @(negedge CLOCK_50);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
    endtask

    task automatic pulse_irq_ack();
        @(negedge CLOCK_50);
        irq_ack = 1'b1;
        @(negedge CLOCK_50);
        irq_ack = 1'b0;
    endtask

    // Poll busy and then expect exactly one byte from the line monitor
    task automatic wait_uart_frame(input logic [7:0] expected);
        logic [DATA_W-1:0] st;
        int                polls;
        st    = ST_BUSY;
        polls = 0;
        while (st[UART_BUSY_BIT] && polls < UART_FRAME) begin
            wb_read(UART_STAT_ADDR, st);
            polls++;
        end
        if (st[UART_BUSY_BIT]) begin
            errors++;
            $display("UART stayed busy after %0d status reads", polls);
        end
        check_value(rx_bytes.size(), 1, "UART frames received");
        if (rx_bytes.size() > 0) begin
            check_value(32'(rx_bytes[0]), 32'(expected), "UART byte on txd");
        end
        rx_bytes.delete();
    endtask

    task automatic run_step(input step_t s);
        logic [DATA_W-1:0] rd;
        case (s.op)
            OP_WRITE:   wb_write(s.addr, s.data);
            OP_READ: begin
                wb_read(s.addr, rd);
                check_value(rd, s.expected, $sformatf("read of %h", s.addr));
            end
            OP_PS2:     ps2_send(s.data[7:0], 1'b0);
            OP_PS2_BAD: ps2_send(s.data[7:0], 1'b1);
            OP_IRQ_ACK: pulse_irq_ack();
            OP_IRQ: begin
                @(negedge CLOCK_50);
                check_value(32'(irq), s.expected, "irq level");
            end
            OP_UART:    wait_uart_frame(s.expected[7:0]);
            default: begin
                errors++;
                $display("Unknown operation in stimulus table");
            end
        endcase
    endtask

    task automatic build_table();
        logic [ADDR_W-1:0] ram_adr [RAM_TESTS];
        logic [DATA_W-1:0] ram_dat [RAM_TESTS];
        // Two words sit where 16'h2000 and 16'h1008 would land if they aliased
        ram_adr[0] = 16'h0000;
        ram_adr[1] = 16'h0008;
        ram_adr[2] = 16'((256 + $urandom % 256) * 4);
        ram_adr[3] = 16'((512 + $urandom % 512) * 4);
        for (int i = 0; i < RAM_TESTS; i++) begin
            ram_dat[i] = $urandom;
            add_step(OP_WRITE, ram_adr[i], ram_dat[i], '0);
        end
        for (int i = 0; i < RAM_TESTS; i++) begin
            add_step(OP_READ, ram_adr[i], '0, ram_dat[i]);
        end
        add_step(OP_WRITE, 16'h2000, $urandom, '0);
        add_step(OP_WRITE, 16'h1008, $urandom, '0);
        add_step(OP_READ, 16'h2000, '0, '0);
        add_step(OP_READ, 16'h1008, '0, '0);
        for (int i = 0; i < RAM_TESTS; i++) begin
            add_step(OP_READ, ram_adr[i], '0, ram_dat[i]);
        end
        // Keyboard good frame and interrupt
        add_step(OP_IRQ, '0, '0, 32'd0);
        add_step(OP_READ, KEY_STAT_ADDR, '0, '0);
        add_step(OP_PS2, '0, 32'h1c, '0);
        add_step(OP_IRQ, '0, '0, 32'd1);
        add_step(OP_READ, KEY_STAT_ADDR, '0, ST_VALID);
        add_step(OP_READ, KEY_DATA_ADDR, '0, 32'h1c);
        add_step(OP_READ, KEY_STAT_ADDR, '0, '0);
        add_step(OP_IRQ, '0, '0, 32'd1);
        add_step(OP_IRQ_ACK, '0, '0, '0);
        add_step(OP_IRQ, '0, '0, 32'd0);
        // Overrun and then a bad parity frame
        add_step(OP_PS2, '0, 32'h32, '0);
        add_step(OP_PS2, '0, 32'h21, '0);
        add_step(OP_READ, KEY_STAT_ADDR, '0, ST_VALID | ST_OVERRUN);
        add_step(OP_READ, KEY_DATA_ADDR, '0, 32'h21);
        add_step(OP_READ, KEY_STAT_ADDR, '0, '0);
        add_step(OP_IRQ_ACK, '0, '0, '0);
        add_step(OP_PS2_BAD, '0, 32'h45, '0);
        add_step(OP_READ, KEY_STAT_ADDR, '0, ST_PARITY);
        add_step(OP_READ, KEY_DATA_ADDR, '0, 32'h21);
        add_step(OP_READ, KEY_STAT_ADDR, '0, '0);
        add_step(OP_IRQ, '0, '0, 32'd0);
        // UART frame with a second write while busy
        add_step(OP_WRITE, UART_DATA_ADDR, 32'ha5, '0);
        add_step(OP_READ, UART_STAT_ADDR, '0, ST_BUSY);
        add_step(OP_WRITE, UART_DATA_ADDR, 32'h3c, '0);
        add_step(OP_UART, '0, '0, 32'ha5);
        add_step(OP_READ, UART_STAT_ADDR, '0, '0);
        add_step(OP_READ, UART_DATA_ADDR, '0, 32'ha5);
    endtask

    // Line monitor sampling each bit at its middle
    initial begin
        logic [7:0] rx;
        wait (KEY0 === 1'b1);
        forever begin
            @(negedge uart_txd);
            repeat (BAUD_DIV / 2) @(negedge CLOCK_50);
            check_value(32'(uart_txd), 32'd0, "UART start bit");
            for (int b = 0; b < 8; b++) begin
                repeat (BAUD_DIV) @(negedge CLOCK_50);
                rx[b] = uart_txd;
            end
            repeat (BAUD_DIV) @(negedge CLOCK_50);
            check_value(32'(uart_txd), 32'd1, "UART stop bit");
            rx_bytes.push_back(rx);
        end
    end

    initial begin
        longint limit_ns;
        wait (table_ready === 1'b1);
        limit_ns = longint'(steps.size()) * LONGEST_STEP * CLK_PERIOD * 2;
        #(limit_ns);
        $display("Watchdog expired after %0d ns, the test did not finish", limit_ns);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int idx;
        KEY0        = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        ps2_clk     = 1'b1;
        ps2_dat     = 1'b1;
        irq_ack     = 1'b0;
        table_ready = 1'b0;
        seed_val    = $urandom(32'h560f);
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        for (idx = 0; idx < steps.size(); idx++) begin
            run_step(steps[idx]);
        end
        repeat (4) @(negedge CLOCK_50);
        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, DUT.u_props.fail_count);
        if (errors == 0 && DUT.u_props.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int BAUD_DIV = 434
) (
    input  logic         CLOCK_50,
    input  logic         KEY0,
    periph_if.peripheral bus,
    output logic         txd
);
    import board_pkg::*;

    localparam int CNT_W = $clog2(BAUD_DIV);
    localparam logic [ADDR_W-3:0] DATA_WORD = UART_DATA_ADDR[ADDR_W-1:2];

    uart_state_e       state;
    logic [CNT_W-1:0]  baud_cnt;
    logic [2:0]        bit_cnt;
    logic [2:0]        next_bit;
    logic [7:0]        tx_byte;
    logic              start_wr;
    logic              bit_end;
    logic              busy;
    logic [DATA_W-1:0] status;

    // Writes while busy are dropped
    assign start_wr = bus.sel && bus.we && (bus.addr == DATA_WORD) && (state == UART_IDLE);
    assign bit_end  = (baud_cnt == CNT_W'(BAUD_DIV - 1));
    assign next_bit = bit_cnt + 3'd1;
    assign busy     = (state != UART_IDLE);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state    <= UART_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= 3'd0;
            txd      <= 1'b1;
        end else begin
            if (state == UART_IDLE) begin
                baud_cnt <= '0;
                if (start_wr) begin
                    state <= UART_START;
                    txd   <= 1'b0;
                end
            end else if (!bit_end) begin
                baud_cnt <= baud_cnt + CNT_W'(1);
            end else begin
                baud_cnt <= '0;
                case (state)
                    UART_START: begin
                        state   <= UART_DATA;
                        bit_cnt <= 3'd0;
                        txd     <= tx_byte[0];
                    end
                    UART_DATA: begin
                        if (bit_cnt == 3'd7) begin
                            state <= UART_STOP;
                            txd   <= 1'b1;
                        end else begin
                            bit_cnt <= next_bit;
                            txd     <= tx_byte[next_bit];
                        end
                    end
                    default: state <= UART_IDLE;
                endcase
            end
        end
    end

    always_comb begin
        status                = '0;
        status[UART_BUSY_BIT] = busy;
    end

    always_ff @(posedge CLOCK_50) begin
        if (start_wr) begin
            tx_byte <= bus.wdata[7:0];
        end
        if (bus.sel) begin
            bus.rdata <= (bus.addr == DATA_WORD) ? {{(DATA_W-8){1'b0}}, tx_byte} : status;
        end
    end

endmodule

`default_nettype wire
